// ==== source/pwo_pkg.sv ====
// Pointwise engine shared definitions

package pwo_pkg;

    // ==================================================
    // Arithmetic
    // ==================================================

    // ML-DSA modulus, 2^23 - 2^13 + 1
    localparam logic [22:0] MLDSA_Q = 23'd8380417;

    localparam int COEFF_WIDTH = 23;

    // One spare top bit per slot, always written as zero
    localparam int SLOT_WIDTH = 24;

    // ==================================================
    // Memory layout
    // ==================================================

    localparam int LANES          = 4;
    localparam int WORD_WIDTH     = LANES * SLOT_WIDTH;
    localparam int WORDS_PER_POLY = 64;
    localparam int COUNT_WIDTH    = 6;

    // Pointwise operations
    typedef enum logic [1:0] {
        PWO_MUL = 2'b00,
        PWO_ADD = 2'b01,
        PWO_SUB = 2'b10
    } pwo_mode_t;

endpackage

// ==== source/pwo_decode.sv ====
// Pointwise engine decode
`timescale 1ns/1ps

module pwo_decode #(
    parameter int ADDR_WIDTH = 15
) (
    input  logic                    clk,
    input  logic                    reset_n,

    input  logic                    enable_i,
    input  pwo_pkg::pwo_mode_t      mode_i,
    input  logic                    accumulate_i,
    input  logic [ADDR_WIDTH-1:0]   base_a_i,
    input  logic [ADDR_WIDTH-1:0]   base_b_i,
    input  logic [ADDR_WIDTH-1:0]   base_c_i,
    input  logic                    done_i,

    output logic                    a_rd_en_o,
    output logic [ADDR_WIDTH-1:0]   a_rd_addr_o,
    output logic                    b_rd_en_o,
    output logic [ADDR_WIDTH-1:0]   b_rd_addr_o,
    output logic                    c_rd_en_o,
    output logic [ADDR_WIDTH-1:0]   c_rd_addr_o,

    output logic                    op_valid_o,
    output pwo_pkg::pwo_mode_t      op_mode_o,
    output logic                    op_acc_o,
    output logic [ADDR_WIDTH-1:0]   op_addr_o,
    output logic                    op_last_o,

    output logic                    busy_o
);

    logic                               start;
    logic                               busy_q;
    logic                               rd_en_q;
    logic [pwo_pkg::COUNT_WIDTH-1:0]    count_q;
    logic                               count_last;
    pwo_pkg::pwo_mode_t                 mode_q;
    logic                               acc_q;
    logic [ADDR_WIDTH-1:0]              base_a_q;
    logic [ADDR_WIDTH-1:0]              base_b_q;
    logic [ADDR_WIDTH-1:0]              base_c_q;
    logic [ADDR_WIDTH-1:0]              offset;

    // Start pulses while running are dropped
    assign start      = enable_i && !busy_q;
    assign count_last = (count_q == pwo_pkg::COUNT_WIDTH'(pwo_pkg::WORDS_PER_POLY - 1));
    assign offset     = ADDR_WIDTH'(count_q);

    // ==================================================
    // Run control and word counter
    // ==================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q  <= 1'b0;
            rd_en_q <= 1'b0;
            count_q <= '0;
            mode_q  <= pwo_pkg::PWO_MUL;
            acc_q   <= 1'b0;
        end else begin
            if (start) begin
                busy_q <= 1'b1;
                mode_q <= mode_i;
                acc_q  <= accumulate_i;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end

            // One word read per cycle, 64 in a row
            if (start) begin
                rd_en_q <= 1'b1;
                count_q <= '0;
            end else if (rd_en_q) begin
                count_q <= count_q + 1'b1;
                if (count_last) begin
                    rd_en_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            base_a_q <= base_a_i;
            base_b_q <= base_b_i;
            base_c_q <= base_c_i;
        end
    end

    // Read strobes, c only for an accumulating multiply
    assign a_rd_en_o   = rd_en_q;
    assign b_rd_en_o   = rd_en_q;
    assign c_rd_en_o   = rd_en_q && acc_q && (mode_q == pwo_pkg::PWO_MUL);
    assign a_rd_addr_o = base_a_q + offset;
    assign b_rd_addr_o = base_b_q + offset;
    assign c_rd_addr_o = base_c_q + offset;

    // ==================================================
    // Operation tags, aligned with read data
    // ==================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            op_valid_o <= 1'b0;
            op_last_o  <= 1'b0;
        end else begin
            op_valid_o <= rd_en_q;
            op_last_o  <= rd_en_q && count_last;
        end
    end

    // Destination is the same word of c
    always_ff @(posedge clk) begin
        op_mode_o <= mode_q;
        op_acc_o  <= acc_q;
        op_addr_o <= c_rd_addr_o;
    end

    assign busy_o = busy_q;

endmodule

// ==== source/pwo_execute.sv ====
// Pointwise lane arithmetic
`timescale 1ns/1ps

module pwo_execute #(
    parameter int ADDR_WIDTH = 15
) (
    input  logic                            clk,
    input  logic                            reset_n,

    input  logic                            op_valid_i,
    input  pwo_pkg::pwo_mode_t              op_mode_i,
    input  logic                            op_acc_i,
    input  logic [ADDR_WIDTH-1:0]           op_addr_i,
    input  logic                            op_last_i,
    input  logic [pwo_pkg::WORD_WIDTH-1:0]  a_data_i,
    input  logic [pwo_pkg::WORD_WIDTH-1:0]  b_data_i,
    input  logic [pwo_pkg::WORD_WIDTH-1:0]  c_data_i,

    output logic                            res_valid_o,
    output logic [pwo_pkg::WORD_WIDTH-1:0]  res_word_o,
    output logic [ADDR_WIDTH-1:0]           res_addr_o,
    output logic                            res_last_o
);

    localparam int CW = pwo_pkg::COEFF_WIDTH;
    localparam int SW = pwo_pkg::SLOT_WIDTH;
    localparam int VAL_WIDTH = 2 * CW;

    logic [VAL_WIDTH-1:0]           s1_next [pwo_pkg::LANES];
    logic [CW-1:0]                  c_next  [pwo_pkg::LANES];
    logic [VAL_WIDTH-1:0]           s1_val  [pwo_pkg::LANES];
    logic [CW-1:0]                  s1_c    [pwo_pkg::LANES];
    logic                           s1_valid;
    logic                           s1_last;
    logic [ADDR_WIDTH-1:0]          s1_addr;
    logic [pwo_pkg::WORD_WIDTH-1:0] res_next;

    // Folds 2^23 into 2^13 - 1 three times, then one conditional subtract
    function automatic logic [CW-1:0] mod_q(input logic [VAL_WIDTH-1:0] x);
        logic [35:0] x1;
        logic [26:0] x2;
        logic [23:0] x3;
        x1 = {x[45:23], 13'b0} - 36'(x[45:23]) + 36'(x[22:0]);
        x2 = 27'({x1[35:23], 13'b0}) - 27'(x1[35:23]) + 27'(x1[22:0]);
        x3 = 24'({x2[26:23], 13'b0}) - 24'(x2[26:23]) + 24'(x2[22:0]);
        return (x3 >= 24'(pwo_pkg::MLDSA_Q)) ? CW'(x3 - 24'(pwo_pkg::MLDSA_Q)) : x3[CW-1:0];
    endfunction

    // ==================================================
    // Stage one: raw product, sum or difference
    // ==================================================

    always_comb begin
        for (int l = 0; l < pwo_pkg::LANES; l++) begin
            case (op_mode_i)
                pwo_pkg::PWO_MUL: s1_next[l] = VAL_WIDTH'(a_data_i[l*SW +: CW]) *
                                               VAL_WIDTH'(b_data_i[l*SW +: CW]);
                pwo_pkg::PWO_ADD: s1_next[l] = VAL_WIDTH'(a_data_i[l*SW +: CW]) +
                                               VAL_WIDTH'(b_data_i[l*SW +: CW]);
                // a + (Q - b) stays non-negative
                default:          s1_next[l] = VAL_WIDTH'(a_data_i[l*SW +: CW]) +
                                               VAL_WIDTH'(pwo_pkg::MLDSA_Q - b_data_i[l*SW +: CW]);
            endcase
            c_next[l] = (op_acc_i && op_mode_i == pwo_pkg::PWO_MUL) ? c_data_i[l*SW +: CW] : '0;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid    <= 1'b0;
            s1_last     <= 1'b0;
            res_valid_o <= 1'b0;
            res_last_o  <= 1'b0;
        end else begin
            s1_valid    <= op_valid_i;
            s1_last     <= op_valid_i && op_last_i;
            res_valid_o <= s1_valid;
            res_last_o  <= s1_valid && s1_last;
        end
    end

    // ==================================================
    // Stage two: reduce, add c, reduce again
    // ==================================================

    // c is zero unless accumulating, so the second reduce is harmless
    always_comb begin
        for (int l = 0; l < pwo_pkg::LANES; l++) begin
            res_next[l*SW +: SW] = {1'b0, mod_q(VAL_WIDTH'(mod_q(s1_val[l])) +
                                                VAL_WIDTH'(s1_c[l]))};
        end
    end

    always_ff @(posedge clk) begin
        s1_val     <= s1_next;
        s1_c       <= c_next;
        s1_addr    <= op_addr_i;
        res_word_o <= res_next;
        res_addr_o <= s1_addr;
    end

endmodule

// ==== source/pwo_result.sv ====
// Pointwise write request
`timescale 1ns/1ps

module pwo_result #(
    parameter int ADDR_WIDTH = 15
) (
    input  logic                            clk,
    input  logic                            reset_n,

    input  logic                            res_valid_i,
    input  logic [pwo_pkg::WORD_WIDTH-1:0]  res_word_i,
    input  logic [ADDR_WIDTH-1:0]           res_addr_i,
    input  logic                            res_last_i,

    output logic                            wr_en_o,
    output logic [ADDR_WIDTH-1:0]           wr_addr_o,
    output logic [pwo_pkg::WORD_WIDTH-1:0]  wr_data_o,
    output logic                            done_o
);

    // ==================================================
    // Destination write port
    // ==================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_en_o <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            wr_en_o <= res_valid_i;
            // Single pulse alongside the final write
            done_o  <= res_valid_i && res_last_i;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr_o <= res_addr_i;
        wr_data_o <= res_word_i;
    end

endmodule

// ==== source/pwo_top.sv ====
// Pointwise engine top level
`timescale 1ns/1ps

module pwo_top #(
    parameter int ADDR_WIDTH = 15
) (
    input  logic                            clk,
    input  logic                            reset_n,

    // Control
    input  logic                            enable_i,
    input  pwo_pkg::pwo_mode_t              mode_i,
    input  logic                            accumulate_i,
    input  logic [ADDR_WIDTH-1:0]           base_a_i,
    input  logic [ADDR_WIDTH-1:0]           base_b_i,
    input  logic [ADDR_WIDTH-1:0]           base_c_i,

    // Operand read ports
    output logic                            a_rd_en_o,
    output logic [ADDR_WIDTH-1:0]           a_rd_addr_o,
    input  logic [pwo_pkg::WORD_WIDTH-1:0]  a_rd_data_i,
    output logic                            b_rd_en_o,
    output logic [ADDR_WIDTH-1:0]           b_rd_addr_o,
    input  logic [pwo_pkg::WORD_WIDTH-1:0]  b_rd_data_i,
    output logic                            c_rd_en_o,
    output logic [ADDR_WIDTH-1:0]           c_rd_addr_o,
    input  logic [pwo_pkg::WORD_WIDTH-1:0]  c_rd_data_i,

    // Destination write port
    output logic                            wr_en_o,
    output logic [ADDR_WIDTH-1:0]           wr_addr_o,
    output logic [pwo_pkg::WORD_WIDTH-1:0]  wr_data_o,

    output logic                            busy_o,
    output logic                            done_o
);

    logic                           op_valid;
    pwo_pkg::pwo_mode_t             op_mode;
    logic                           op_acc;
    logic [ADDR_WIDTH-1:0]          op_addr;
    logic                           op_last;
    logic                           res_valid;
    logic [pwo_pkg::WORD_WIDTH-1:0] res_word;
    logic [ADDR_WIDTH-1:0]          res_addr;
    logic                           res_last;
    logic                           done;

    assign done_o = done;

    pwo_decode #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_decode (
        .clk(clk),
        .reset_n(reset_n),
        .enable_i(enable_i),
        .mode_i(mode_i),
        .accumulate_i(accumulate_i),
        .base_a_i(base_a_i),
        .base_b_i(base_b_i),
        .base_c_i(base_c_i),
        .done_i(done),
        .a_rd_en_o(a_rd_en_o),
        .a_rd_addr_o(a_rd_addr_o),
        .b_rd_en_o(b_rd_en_o),
        .b_rd_addr_o(b_rd_addr_o),
        .c_rd_en_o(c_rd_en_o),
        .c_rd_addr_o(c_rd_addr_o),
        .op_valid_o(op_valid),
        .op_mode_o(op_mode),
        .op_acc_o(op_acc),
        .op_addr_o(op_addr),
        .op_last_o(op_last),
        .busy_o(busy_o)
    );

    pwo_execute #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_execute (
        .clk(clk),
        .reset_n(reset_n),
        .op_valid_i(op_valid),
        .op_mode_i(op_mode),
        .op_acc_i(op_acc),
        .op_addr_i(op_addr),
        .op_last_i(op_last),
        .a_data_i(a_rd_data_i),
        .b_data_i(b_rd_data_i),
        .c_data_i(c_rd_data_i),
        .res_valid_o(res_valid),
        .res_word_o(res_word),
        .res_addr_o(res_addr),
        .res_last_o(res_last)
    );

    pwo_result #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_result (
        .clk(clk),
        .reset_n(reset_n),
        .res_valid_i(res_valid),
        .res_word_i(res_word),
        .res_addr_i(res_addr),
        .res_last_i(res_last),
        .wr_en_o(wr_en_o),
        .wr_addr_o(wr_addr_o),
        .wr_data_o(wr_data_o),
        .done_o(done)
    );

endmodule

// ==== sim/pwo_props.sv ====
// Pointwise engine port assertions
`timescale 1ns/1ps

module pwo_props (
    input logic                 clk,
    input logic                 reset_n,
    input logic                 enable_i,
    input pwo_pkg::pwo_mode_t   mode_i,
    input logic                 accumulate_i,
    input logic                 busy_o,
    input logic                 a_rd_en_o,
    input logic                 c_rd_en_o,
    input logic                 wr_en_o,
    input logic                 done_o
);

    int unsigned fail_count = 0;
    logic        acc_mul_run;

    // Kind of the run that was last accepted
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc_mul_run <= 1'b0;
        end else if (enable_i && !busy_o) begin
            acc_mul_run <= accumulate_i && (mode_i == pwo_pkg::PWO_MUL);
        end
    end

    wr_in_run: assert property (@(posedge clk) disable iff (!reset_n) wr_en_o |-> busy_o)
        else begin
            $error("wr_en_o high while busy_o is low");
            fail_count++;
        end

    done_single: assert property (@(posedge clk) disable iff (!reset_n) done_o |=> !done_o)
        else begin
            $error("done_o high for more than one cycle");
            fail_count++;
        end

    c_read_acc_only: assert property (@(posedge clk) disable iff (!reset_n)
        c_rd_en_o |-> (busy_o && acc_mul_run))
        else begin
            $error("c_rd_en_o high outside an accumulating multiply");
            fail_count++;
        end

    wr_after_read: assert property (@(posedge clk) disable iff (!reset_n)
        wr_en_o |-> $past(a_rd_en_o, 4))
        else begin
            $error("write not 4 cycles after its read");
            fail_count++;
        end

endmodule

bind pwo_top pwo_props u_props (
    .clk(clk),
    .reset_n(reset_n),
    .enable_i(enable_i),
    .mode_i(mode_i),
    .accumulate_i(accumulate_i),
    .busy_o(busy_o),
    .a_rd_en_o(a_rd_en_o),
    .c_rd_en_o(c_rd_en_o),
    .wr_en_o(wr_en_o),
    .done_o(done_o)
);

// ==== sim/pwo_tb.sv ====
// Pointwise engine testbench
`timescale 1ns/1ps

module pwo_tb;

    localparam int ADDR_WIDTH = 15;
    localparam int WW = pwo_pkg::WORD_WIDTH;
    localparam int SW = pwo_pkg::SLOT_WIDTH;
    localparam int CW = pwo_pkg::COEFF_WIDTH;
    localparam logic [63:0] Q = 64'(pwo_pkg::MLDSA_Q);

    logic clk = 1'b0;
    logic reset_n;
    logic enable_i;
    pwo_pkg::pwo_mode_t mode_i;
    logic accumulate_i;
    logic [ADDR_WIDTH-1:0] base_a_i, base_b_i, base_c_i;
    logic a_rd_en_o, b_rd_en_o, c_rd_en_o, wr_en_o, busy_o, done_o;
    logic [ADDR_WIDTH-1:0] a_rd_addr_o, b_rd_addr_o, c_rd_addr_o, wr_addr_o;
    logic [WW-1:0] a_rd_data_i, b_rd_data_i, c_rd_data_i, wr_data_o;

    logic [WW-1:0] a_mem [2**ADDR_WIDTH];
    logic [WW-1:0] b_mem [2**ADDR_WIDTH];
    logic [WW-1:0] c_mem [2**ADDR_WIDTH];
    logic [WW-1:0] exp_word [pwo_pkg::WORDS_PER_POLY];

    integer seed = 32'hac96cac7;
    pwo_pkg::pwo_mode_t exp_mode = pwo_pkg::PWO_ADD;
    logic exp_acc = 1'b0;
    logic [ADDR_WIDTH-1:0] exp_base_a, exp_base_b, exp_base_c;
    int rd_count = 0;
    int wr_count = 0;
    logic [3:0] rd_hist = '0;

    // Expected run state, advanced from the accepted start
    logic exp_busy = 1'b0;
    logic exp_rd;
    logic exp_done;
    int   rd_left = 0;

    pwo_top #(.ADDR_WIDTH(ADDR_WIDTH)) u_dut (.*);

    always #50 clk = ~clk;

    // ==================================================
    // Memory models, one cycle read latency
    // ==================================================

    always @(posedge clk) begin
        if (a_rd_en_o) a_rd_data_i <= a_mem[a_rd_addr_o];
        if (b_rd_en_o) b_rd_data_i <= b_mem[b_rd_addr_o];
        if (c_rd_en_o) c_rd_data_i <= c_mem[c_rd_addr_o];
        if (wr_en_o) c_mem[wr_addr_o] <= wr_data_o;
    end

    task automatic abort_test();
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_word(input string name, input logic [WW-1:0] exp,
                                input logic [WW-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%h actual 0x%h", name, exp, act);
            abort_test();
        end
    endtask

    task automatic compare_addr(input string name, input logic [ADDR_WIDTH-1:0] exp,
                                input logic [ADDR_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%h actual 0x%h", name, exp, act);
            abort_test();
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%h actual 0x%h", name, exp, act);
            abort_test();
        end
    endtask

    // Random word, every lane below Q and padding zero
    function automatic logic [WW-1:0] rand_word();
        logic [WW-1:0] w;
        w = '0;
        for (int l = 0; l < pwo_pkg::LANES; l++) begin
            w[l*SW +: CW] = CW'($unsigned($random(seed)) % pwo_pkg::MLDSA_Q);
        end
        return w;
    endfunction

    function automatic logic [WW-1:0] model_word(input pwo_pkg::pwo_mode_t mode,
                                                 input logic acc, input logic [WW-1:0] a,
                                                 input logic [WW-1:0] b,
                                                 input logic [WW-1:0] c);
        logic [63:0] x, y, z, r;
        logic [WW-1:0] w;
        w = '0;
        for (int l = 0; l < pwo_pkg::LANES; l++) begin
            x = 64'(a[l*SW +: CW]);
            y = 64'(b[l*SW +: CW]);
            z = 64'(c[l*SW +: CW]);
            case (mode)
                pwo_pkg::PWO_ADD: r = (x + y) % Q;
                pwo_pkg::PWO_SUB: r = (x + Q - y) % Q;
                default: r = acc ? ((x * y) % Q + z) % Q : (x * y) % Q;
            endcase
            w[l*SW +: CW] = r[CW-1:0];
        end
        return w;
    endfunction

    // ==================================================
    // Strobe, address and data monitor
    // ==================================================

    always @(posedge clk) begin
        if (reset_n) begin
            if (u_dut.u_props.fail_count != 0) begin
                $display("A bound assertion on the DUT ports failed");
                abort_test();
            end
            exp_rd   = (rd_left != 0);
            exp_done = rd_hist[3] && wr_count == pwo_pkg::WORDS_PER_POLY - 1;
            compare_bit("a_rd_en_o", exp_rd, a_rd_en_o);
            compare_bit("b_rd_en_o", exp_rd, b_rd_en_o);
            compare_bit("c_rd_en_o", exp_rd && exp_acc && exp_mode == pwo_pkg::PWO_MUL,
                        c_rd_en_o);
            compare_bit("wr_en_o", rd_hist[3], wr_en_o);
            compare_bit("done_o", exp_done, done_o);
            compare_bit("busy_o", exp_busy, busy_o);
            if (exp_rd) begin
                compare_addr("a_rd_addr_o", ADDR_WIDTH'(exp_base_a + rd_count), a_rd_addr_o);
                compare_addr("b_rd_addr_o", ADDR_WIDTH'(exp_base_b + rd_count), b_rd_addr_o);
                if (c_rd_en_o) begin
                    compare_addr("c_rd_addr_o", ADDR_WIDTH'(exp_base_c + rd_count),
                                 c_rd_addr_o);
                end
                rd_count++;
            end
            if (rd_hist[3]) begin
                compare_addr("wr_addr_o", ADDR_WIDTH'(exp_base_c + wr_count), wr_addr_o);
                compare_word("wr_data_o", exp_word[wr_count % 64], wr_data_o);
                wr_count++;
            end
            rd_hist = {rd_hist[2:0], exp_rd};
            if (rd_left != 0) begin
                rd_left--;
            end
            // A start is taken only while idle
            if (enable_i && !exp_busy) begin
                exp_busy = 1'b1;
                rd_left  = pwo_pkg::WORDS_PER_POLY;
            end else if (exp_done) begin
                exp_busy = 1'b0;
            end
        end
    end

    // Fills operands, builds the expected words, runs and waits for done_o
    task automatic run_op(input pwo_pkg::pwo_mode_t mode, input logic acc,
                          input logic restart);
        int   cycles;
        logic done_seen;
        exp_mode   = mode;
        exp_acc    = acc;
        exp_base_a = ADDR_WIDTH'($random(seed));
        exp_base_b = ADDR_WIDTH'($random(seed));
        exp_base_c = ADDR_WIDTH'($random(seed));
        for (int i = 0; i < pwo_pkg::WORDS_PER_POLY; i++) begin
            a_mem[ADDR_WIDTH'(exp_base_a + i)] = rand_word();
            b_mem[ADDR_WIDTH'(exp_base_b + i)] = rand_word();
            c_mem[ADDR_WIDTH'(exp_base_c + i)] = rand_word();
            exp_word[i] = model_word(mode, acc, a_mem[ADDR_WIDTH'(exp_base_a + i)],
                                     b_mem[ADDR_WIDTH'(exp_base_b + i)],
                                     c_mem[ADDR_WIDTH'(exp_base_c + i)]);
        end
        rd_count = 0;
        wr_count = 0;
        @(posedge clk);
        enable_i     <= 1'b1;
        mode_i       <= mode;
        accumulate_i <= acc;
        base_a_i     <= exp_base_a;
        base_b_i     <= exp_base_b;
        base_c_i     <= exp_base_c;
        @(posedge clk);
        enable_i <= 1'b0;
        @(posedge clk);
        compare_bit("busy_o", 1'b1, busy_o);
        cycles    = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(posedge clk);
            cycles++;
            // Stray start mid-run with other settings
            if (restart && cycles == 20) begin
                enable_i     <= 1'b1;
                mode_i       <= pwo_pkg::PWO_SUB;
                accumulate_i <= 1'b1;
                base_a_i     <= ~exp_base_a;
                base_b_i     <= ~exp_base_b;
                base_c_i     <= ~exp_base_c;
            end
            if (restart && cycles == 21) enable_i <= 1'b0;
            done_seen = (done_o === 1'b1);
            if (!done_seen && cycles >= 200) begin
                $display("done_o did not pulse within 200 cycles of the start");
                abort_test();
            end
        end
        if (cycles + 1 != 68) begin
            $display("done_o came %0d cycles after enable_i instead of 68", cycles + 1);
            abort_test();
        end
        @(posedge clk);
        compare_bit("busy_o", 1'b0, busy_o);
        if (rd_count != 64 || wr_count != 64) begin
            $display("run made %0d reads and %0d writes instead of 64", rd_count, wr_count);
            abort_test();
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        reset_n      = 1'b0;
        enable_i     = 1'b0;
        mode_i       = pwo_pkg::PWO_ADD;
        accumulate_i = 1'b0;
        base_a_i     = '0;
        base_b_i     = '0;
        base_c_i     = '0;
        a_rd_data_i  = '0;
        b_rd_data_i  = '0;
        c_rd_data_i  = '0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        compare_bit("a_rd_en_o", 1'b0, a_rd_en_o);
        compare_bit("b_rd_en_o", 1'b0, b_rd_en_o);
        compare_bit("c_rd_en_o", 1'b0, c_rd_en_o);
        compare_bit("wr_en_o", 1'b0, wr_en_o);
        compare_bit("busy_o", 1'b0, busy_o);
        compare_bit("done_o", 1'b0, done_o);

        run_op(pwo_pkg::PWO_ADD, 1'b0, 1'b0);
        run_op(pwo_pkg::PWO_SUB, 1'b0, 1'b0);
        run_op(pwo_pkg::PWO_MUL, 1'b0, 1'b0);
        run_op(pwo_pkg::PWO_MUL, 1'b1, 1'b0);
        run_op(pwo_pkg::PWO_ADD, 1'b0, 1'b1);
        run_op(pwo_pkg::PWO_MUL, 1'b1, 1'b1);
        repeat (4) @(posedge clk);

        if (u_dut.u_props.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("%0d bound assertion failures", u_dut.u_props.fail_count);
            abort_test();
        end
    end

endmodule

// ==== sources.f ====
source/pwo_pkg.sv
source/pwo_decode.sv
source/pwo_execute.sv
source/pwo_result.sv
source/pwo_top.sv
sim/pwo_props.sv
sim/pwo_tb.sv
